// ==== aq_bus_pkg.sv ====
package aq_bus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Z80 bus widths
    ////////////////////////////////////////////////////////////////////////////
    typedef logic [15:0] addr_t;        // CPU address bus
    typedef logic [7:0]  data_t;        // One data byte
    typedef logic [4:0]  bank_t;        // Physical bank lines bus_ba
    typedef logic [7:0]  io_port_t;     // Low address byte in an I/O cycle

    // One decoded I/O access, single-cycle event
    typedef struct packed {
        logic     wr;                   // Write strobe event
        logic     rd;                   // Read strobe event
        io_port_t port;                 // Addressed port
        data_t    wdata;                // Write data, valid with wr
    } io_cycle_t;

    ////////////////////////////////////////////////////////////////////////////
    // I/O port map
    ////////////////////////////////////////////////////////////////////////////
    // Banking registers, one per 16 KB quadrant
    localparam io_port_t PORT_BANK0  = 8'hF0;
    localparam io_port_t PORT_BANK1  = 8'hF1;
    localparam io_port_t PORT_BANK2  = 8'hF2;
    localparam io_port_t PORT_BANK3  = 8'hF3;

    // Hand controller button bytes, read only
    localparam io_port_t PORT_HCTRL1 = 8'hF7;
    localparam io_port_t PORT_HCTRL2 = 8'hF8;

endpackage

// ==== aq_hctrl_pkg.sv ====
package aq_hctrl_pkg;

    // Button byte of one controller, active low
    typedef logic [7:0] pad_t;

    // Both controllers, pad1 in the upper byte as shifted in first
    typedef struct packed {
        pad_t pad1;
        pad_t pad2;
    } hctrl_state_t;

    // Bits per serial frame, pad1 then pad2
    localparam int unsigned HCTRL_BITS = 16;

endpackage

// ==== phi_gen.sv ====
`timescale 1ns/100ps

module phi_gen #(
    parameter int unsigned PHI_DIV = 4      // sysclk cycles per phi period, even
) (
    input  logic sysclk,
    input  logic rst,
    output logic phi
);

    localparam int unsigned HALF  = PHI_DIV / 2;
    localparam int unsigned CNT_W = (HALF > 1) ? $clog2(HALF) : 1;

    logic [CNT_W-1:0] cnt_q;                // Position within half period
    logic             phi_q;
    logic             half_end;

    assign half_end = (cnt_q == CNT_W'(HALF - 1));

    // Half period counter, phi flips at its wrap
    always_ff @(posedge sysclk) begin
        if (rst) begin
            cnt_q <= '0;
            phi_q <= 1'b0;                  // Held low in reset
        end else if (half_end) begin
            cnt_q <= '0;
            phi_q <= ~phi_q;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign phi = phi_q;                     // 50 % duty

endmodule

// ==== bus_decode.sv ====
`timescale 1ns/100ps

module bus_decode (
    input  logic                  sysclk,
    input  logic                  rst,
    input  aq_bus_pkg::addr_t     bus_a,
    input  aq_bus_pkg::data_t     bus_d_in,
    input  logic                  bus_iorq_n,
    input  logic                  bus_rd_n,
    input  logic                  bus_wr_n,
    input  logic                  bus_m1_n,
    output aq_bus_pkg::io_cycle_t io_cycle,
    output logic                  rd_active
);

    // Z80 control strobes, all active low
    typedef struct packed {
        logic iorq_n;
        logic rd_n;
        logic wr_n;
        logic m1_n;
    } strobe_t;

    ////////////////////////////////////////////////////////////////////////////
    // Two-stage synchronizers
    ////////////////////////////////////////////////////////////////////////////
    strobe_t              strb_s1, strb_s2;
    aq_bus_pkg::io_port_t port_s1, port_s2;
    aq_bus_pkg::data_t    wdata_s1, wdata_s2;

    always_ff @(posedge sysclk) begin
        if (rst) begin
            strb_s1 <= '1;                  // Bus idle
            strb_s2 <= '1;
        end else begin
            strb_s1 <= '{iorq_n: bus_iorq_n, rd_n: bus_rd_n,
                         wr_n: bus_wr_n, m1_n: bus_m1_n};
            strb_s2 <= strb_s1;
        end
    end

    // Byte lanes, stable long before the strobe edge is seen
    always_ff @(posedge sysclk) begin
        port_s1  <= bus_a[7:0];
        port_s2  <= port_s1;
        wdata_s1 <= bus_d_in;
        wdata_s2 <= wdata_s1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Access detection
    ////////////////////////////////////////////////////////////////////////////
    logic io_sel;                           // I/O cycle, not an interrupt ack
    logic cond_wr, cond_rd;
    logic cond_wr_q, cond_rd_q;             // Registered strobe condition
    logic cond_wr_d, cond_rd_d;             // One cycle older, for edge detect
    logic ev_wr_q, ev_rd_q;
    aq_bus_pkg::io_port_t port_q;
    aq_bus_pkg::data_t    wdata_q;

    assign io_sel  = !strb_s2.iorq_n && strb_s2.m1_n;   // M1 low rejects INTA
    assign cond_wr = io_sel && !strb_s2.wr_n;
    assign cond_rd = io_sel && !strb_s2.rd_n;

    always_ff @(posedge sysclk) begin
        if (rst) begin
            cond_wr_q <= 1'b0;
            cond_rd_q <= 1'b0;
            cond_wr_d <= 1'b0;
            cond_rd_d <= 1'b0;
            ev_wr_q   <= 1'b0;
            ev_rd_q   <= 1'b0;
        end else begin
            cond_wr_q <= cond_wr;
            cond_rd_q <= cond_rd;
            cond_wr_d <= cond_wr_q;
            cond_rd_d <= cond_rd_q;
            ev_wr_q   <= cond_wr_q && !cond_wr_d;   // Strobe falling edge
            ev_rd_q   <= cond_rd_q && !cond_rd_d;
        end
    end

    // Event payload
    always_ff @(posedge sysclk) begin
        port_q  <= port_s2;
        wdata_q <= wdata_s2;
    end

    assign io_cycle  = '{wr: ev_wr_q, rd: ev_rd_q, port: port_q, wdata: wdata_q};
    assign rd_active = cond_rd_q;           // Spans the whole read strobe

endmodule

// ==== io_port_block.sv ====
`timescale 1ns/100ps

module io_port_block (
    input  logic                       sysclk,
    input  logic                       rst,
    input  aq_bus_pkg::io_cycle_t      io_cycle,
    input  logic                       rd_active,
    input  aq_hctrl_pkg::hctrl_state_t pads,
    input  logic [1:0]                 bank_sel,     // bus_a[15:14]
    output aq_bus_pkg::bank_t          bus_ba,
    output aq_bus_pkg::data_t          bus_d_out,
    output logic                       bus_d_oe
);

    ////////////////////////////////////////////////////////////////////////////
    // Port decode
    ////////////////////////////////////////////////////////////////////////////
    aq_bus_pkg::data_t bank_q [4];          // Full bytes, low 5 bits reach bus_ba
    aq_bus_pkg::data_t rd_byte;
    logic              rd_hit;              // Port answers reads
    logic              bank_hit;            // Port is a banking register
    logic [1:0]        bank_idx;

    assign bank_idx = io_cycle.port[1:0];   // F0..F3 map to 0..3

    always_comb begin
        rd_hit   = 1'b1;
        bank_hit = 1'b0;
        rd_byte  = '0;
        case (io_cycle.port)
            aq_bus_pkg::PORT_BANK0,
            aq_bus_pkg::PORT_BANK1,
            aq_bus_pkg::PORT_BANK2,
            aq_bus_pkg::PORT_BANK3: begin
                bank_hit = 1'b1;
                rd_byte  = bank_q[bank_idx];
            end
            aq_bus_pkg::PORT_HCTRL1: rd_byte = pads.pad1;
            aq_bus_pkg::PORT_HCTRL2: rd_byte = pads.pad2;
            default: rd_hit = 1'b0;         // Not ours, stay off the bus
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Banking registers
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge sysclk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                bank_q[i] <= aq_bus_pkg::data_t'(i);    // Identity mapping
            end
        end else if (io_cycle.wr && bank_hit) begin
            bank_q[bank_idx] <= io_cycle.wdata;
        end
    end

    // Quadrant to bank lines, no register in this path
    assign bus_ba = aq_bus_pkg::bank_t'(bank_q[bank_sel][4:0]);

    ////////////////////////////////////////////////////////////////////////////
    // Read data and drive enable
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge sysclk) begin
        if (rst) begin
            bus_d_oe <= 1'b0;
        end else if (io_cycle.rd && rd_hit) begin
            bus_d_oe <= 1'b1;
        end else if (!rd_active) begin
            bus_d_oe <= 1'b0;               // Released with the read strobe
        end
    end

    always_ff @(posedge sysclk) begin
        if (io_cycle.rd && rd_hit) begin
            bus_d_out <= rd_byte;           // Held for the rest of the read
        end
    end

endmodule

// ==== handctrl.sv ====
`timescale 1ns/100ps

module handctrl #(
    parameter int unsigned HCTRL_HALF = 8   // sysclk cycles per half hctrl_clk
) (
    input  logic                       sysclk,
    input  logic                       rst,
    output logic                       hctrl_clk,
    output logic                       hctrl_load_n,
    input  logic                       hctrl_data,
    output aq_hctrl_pkg::hctrl_state_t pads
);

    localparam int unsigned NBITS = aq_hctrl_pkg::HCTRL_BITS;
    localparam int unsigned DIV_W = (HCTRL_HALF > 1) ? $clog2(2 * HCTRL_HALF) : 1;
    localparam int unsigned BIT_W = $clog2(NBITS);

    typedef enum logic [1:0] {
        LOAD,                               // Parallel load, clock low
        SHIFT_LO,                           // Clock low half
        SHIFT_HI                            // Clock high half
    } state_t;

    state_t           state_q;
    logic [DIV_W-1:0] div_q;                // Half period divider
    logic [BIT_W-1:0] bit_q;                // Bits taken this frame
    logic [NBITS-1:0] shift_q;
    logic             div_end;
    logic             last_bit;

    // LOAD lasts a full hctrl_clk period
    assign div_end  = (state_q == LOAD) ? (div_q == DIV_W'(2 * HCTRL_HALF - 1))
                                        : (div_q == DIV_W'(HCTRL_HALF - 1));
    assign last_bit = (bit_q == BIT_W'(NBITS - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge sysclk) begin
        if (rst) begin
            state_q <= LOAD;
            div_q   <= '0;
            bit_q   <= '0;
        end else begin
            div_q <= div_end ? '0 : div_q + 1'b1;
            if (div_end) begin
                case (state_q)
                    LOAD:     state_q <= SHIFT_LO;
                    SHIFT_LO: state_q <= SHIFT_HI;
                    SHIFT_HI: begin
                        state_q <= last_bit ? LOAD : SHIFT_LO;
                        bit_q   <= last_bit ? '0 : bit_q + 1'b1;
                    end
                    default:  state_q <= LOAD;
                endcase
            end
        end
    end

    // Pin drivers follow the state one cycle later, idle during reset
    always_ff @(posedge sysclk) begin
        if (rst) begin
            hctrl_clk    <= 1'b0;
            hctrl_load_n <= 1'b1;
        end else begin
            hctrl_clk    <= (state_q == SHIFT_HI);
            hctrl_load_n <= (state_q != LOAD);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Data capture
    ////////////////////////////////////////////////////////////////////////////
    // Sample on the cycle hctrl_clk rises, MSB first
    always_ff @(posedge sysclk) begin
        if (state_q == SHIFT_HI && div_q == '0) begin
            shift_q <= {shift_q[NBITS-2:0], hctrl_data};
        end
    end

    // Publish both bytes at frame end, stored as received
    always_ff @(posedge sysclk) begin
        if (rst) begin
            pads <= '1;                     // No buttons pressed
        end else if (state_q == SHIFT_HI && div_end && last_bit) begin
            pads <= aq_hctrl_pkg::hctrl_state_t'(shift_q);
        end
    end

endmodule

// ==== aq_core_top.sv ====
`timescale 1ns/100ps

module aq_core_top #(
    parameter int unsigned PHI_DIV    = 4,  // sysclk cycles per phi period
    parameter int unsigned HCTRL_HALF = 8   // sysclk cycles per half hctrl_clk
) (
    input  logic              sysclk,
    input  logic              rst,

    // Z80 bus
    output logic              phi,
    input  aq_bus_pkg::addr_t bus_a,
    input  aq_bus_pkg::data_t bus_d_in,
    input  logic              bus_iorq_n,
    input  logic              bus_rd_n,
    input  logic              bus_wr_n,
    input  logic              bus_m1_n,
    output aq_bus_pkg::bank_t bus_ba,
    output aq_bus_pkg::data_t bus_d_out,
    output logic              bus_d_oe,     // Pad driver enable, outside

    // Hand controllers
    output logic              hctrl_clk,
    output logic              hctrl_load_n,
    input  logic              hctrl_data
);

    aq_bus_pkg::io_cycle_t      io_cycle;
    logic                       rd_active;
    aq_hctrl_pkg::hctrl_state_t pads;

    ////////////////////////////////////////////////////////////////////////////
    // CPU clock
    ////////////////////////////////////////////////////////////////////////////
    phi_gen #(.PHI_DIV(PHI_DIV)) u_phi_gen (
        .sysclk (sysclk),
        .rst    (rst),
        .phi    (phi)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Bus interface and I/O ports
    ////////////////////////////////////////////////////////////////////////////
    bus_decode u_bus_decode (
        .sysclk     (sysclk),
        .rst        (rst),
        .bus_a      (bus_a),
        .bus_d_in   (bus_d_in),
        .bus_iorq_n (bus_iorq_n),
        .bus_rd_n   (bus_rd_n),
        .bus_wr_n   (bus_wr_n),
        .bus_m1_n   (bus_m1_n),
        .io_cycle   (io_cycle),
        .rd_active  (rd_active)
    );

    io_port_block u_io_port_block (
        .sysclk    (sysclk),
        .rst       (rst),
        .io_cycle  (io_cycle),
        .rd_active (rd_active),
        .pads      (pads),
        .bank_sel  (bus_a[15:14]),          // Address quadrant
        .bus_ba    (bus_ba),
        .bus_d_out (bus_d_out),
        .bus_d_oe  (bus_d_oe)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Hand controller interface
    ////////////////////////////////////////////////////////////////////////////
    handctrl #(.HCTRL_HALF(HCTRL_HALF)) u_handctrl (
        .sysclk       (sysclk),
        .rst          (rst),
        .hctrl_clk    (hctrl_clk),
        .hctrl_load_n (hctrl_load_n),
        .hctrl_data   (hctrl_data),
        .pads         (pads)
    );

endmodule

// ==== aq_core_chk.sv ====
`timescale 1ns/100ps

module aq_core_chk (
    input logic              sysclk,
    input logic              rst,
    input logic              bus_rd_n,
    input logic              bus_d_oe,
    input logic              hctrl_clk,
    input logic              hctrl_load_n,
    input aq_bus_pkg::bank_t bus_ba
);

    ////////////////////////////////////////////////////////////////////////////
    // Z80 data bus drive
    // Data pads only turn on inside a read strobe
    oe_inside_read: assert property (@(posedge sysclk) disable iff (rst)
        $rose(bus_d_oe) |-> !bus_rd_n)
        else $error("bus_d_oe rose while bus_rd_n was high");

    ////////////////////////////////////////////////////////////////////////////
    // Controller shift register pins
    // Shift clock parked low through the load pulse and one cycle past it
    clk_low_in_load: assert property (@(posedge sysclk) disable iff (rst)
        !hctrl_load_n |-> !hctrl_clk [*2])
        else $error("hctrl_clk high during or right after hctrl_load_n pulse");

    // Bank lines fully driven once out of reset
    ba_known: assert property (@(posedge sysclk) disable iff (rst)
        !$isunknown(bus_ba))
        else $error("bus_ba has unknown bits");

endmodule

// ==== tb_aq_core_top.sv ====
`timescale 1ns/100ps

module tb_aq_core_top;

    localparam int unsigned PHI_DIV     = 4;
    localparam int unsigned HCTRL_HALF  = 8;
    localparam int unsigned FRAME_CYC   = (2 + 2 * aq_hctrl_pkg::HCTRL_BITS) * HCTRL_HALF;
    localparam int          N_ROWS      = 12;
    localparam int          CYCLE_LIMIT = N_ROWS * 40 + 6 * FRAME_CYC + 2000;
    localparam int          DRV_DLY     = 2;    // Input drive after rising edge
    localparam int          MODEL_DLY   = 1;    // Controller model update

    typedef enum logic [1:0] {ROW_BANK, ROW_PAD, ROW_OTHER, ROW_INTA} row_kind_t;

    // One table row, stimulus and expected results
    typedef struct packed {
        row_kind_t                    kind;
        aq_bus_pkg::io_port_t         port;
        aq_bus_pkg::data_t            wval;     // Byte written
        logic [15:0]                  pattern;  // Controller frame
        aq_bus_pkg::bank_t [3:0]      exp_ba;   // Per quadrant
        aq_bus_pkg::data_t            exp_rd;   // Read back or pad1
        aq_bus_pkg::data_t            exp_rd2;  // pad2
    } row_t;

    localparam row_kind_t ROW_KIND [N_ROWS] = '{ROW_BANK, ROW_BANK, ROW_BANK, ROW_BANK,
        ROW_PAD, ROW_OTHER, ROW_INTA, ROW_BANK, ROW_PAD, ROW_OTHER, ROW_BANK, ROW_PAD};
    localparam aq_bus_pkg::io_port_t ROW_PORT [N_ROWS] = '{aq_bus_pkg::PORT_BANK0,
        aq_bus_pkg::PORT_BANK1, aq_bus_pkg::PORT_BANK2, aq_bus_pkg::PORT_BANK3,
        aq_bus_pkg::PORT_HCTRL1, 8'hF5, aq_bus_pkg::PORT_BANK1, aq_bus_pkg::PORT_BANK2,
        aq_bus_pkg::PORT_HCTRL1, 8'h3C, aq_bus_pkg::PORT_BANK0, aq_bus_pkg::PORT_HCTRL1};

    logic sysclk, rst, phi, bus_iorq_n, bus_rd_n, bus_wr_n, bus_m1_n;
    logic bus_d_oe, hctrl_clk, hctrl_load_n, hctrl_data;
    aq_bus_pkg::addr_t bus_a;
    aq_bus_pkg::data_t bus_d_in, bus_d_out;
    aq_bus_pkg::bank_t bus_ba;
    logic [15:0] ctrl_pattern;
    logic [15:0] ctrl_sr  = '1;                 // External shift register
    logic        clk_prev = 1'b0;
    row_t        table_q [N_ROWS];
    int          cycle_cnt = 0;
    int          err_cnt   = 0;

    aq_core_top #(.PHI_DIV(PHI_DIV), .HCTRL_HALF(HCTRL_HALF)) u_aq_core_top (
        .sysclk(sysclk), .rst(rst), .phi(phi), .bus_a(bus_a), .bus_d_in(bus_d_in),
        .bus_iorq_n(bus_iorq_n), .bus_rd_n(bus_rd_n), .bus_wr_n(bus_wr_n),
        .bus_m1_n(bus_m1_n), .bus_ba(bus_ba), .bus_d_out(bus_d_out), .bus_d_oe(bus_d_oe),
        .hctrl_clk(hctrl_clk), .hctrl_load_n(hctrl_load_n), .hctrl_data(hctrl_data)
    );

    bind aq_core_top aq_core_chk u_aq_core_chk (
        .sysclk(sysclk), .rst(rst), .bus_rd_n(bus_rd_n), .bus_d_oe(bus_d_oe),
        .hctrl_clk(hctrl_clk), .hctrl_load_n(hctrl_load_n), .bus_ba(bus_ba)
    );

    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;           // 20 ns period
    end

    always @(posedge sysclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) stop_on_error("Timeout, the run exceeded its cycle limit");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Hand controller shift register model
    assign hctrl_data = ctrl_sr[15];            // MSB on the serial pin
    always @(posedge sysclk) begin
        #MODEL_DLY;
        if (!hctrl_load_n) begin
            ctrl_sr = ctrl_pattern;             // Parallel load
        end else if (clk_prev && !hctrl_clk) begin
            ctrl_sr = {ctrl_sr[14:0], 1'b1};    // Shift on falling clock
        end
        clk_prev = hctrl_clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    task automatic stop_on_error(input string msg);
        err_cnt++;
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_bank(input string name, input aq_bus_pkg::bank_t got,
                              input aq_bus_pkg::bank_t exp);
        if (got !== exp) stop_on_error($sformatf("FAILED time=%0t %s got=%h expected=%h",
                                                 $time, name, got, exp));
    endtask

    task automatic check_data(input string name, input aq_bus_pkg::data_t got,
                              input aq_bus_pkg::data_t exp);
        if (got !== exp) stop_on_error($sformatf("FAILED time=%0t %s got=%h expected=%h",
                                                 $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) stop_on_error($sformatf("FAILED time=%0t %s got=%b expected=%b",
                                                 $time, name, got, exp));
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Z80 bus access, strobes held 8 cycles
    task automatic io_access(input aq_bus_pkg::io_port_t port, input aq_bus_pkg::data_t wdata,
                             input logic is_rd, input logic m1_n,
                             output aq_bus_pkg::data_t rdata, output logic oe_last,
                             output logic oe_any);
        @(posedge sysclk);
        #DRV_DLY;
        bus_a      = {8'h00, port};             // Port on the low byte
        bus_d_in   = wdata;
        bus_m1_n   = m1_n;
        bus_iorq_n = 1'b0;
        bus_rd_n   = !is_rd;
        bus_wr_n   = is_rd;
        oe_any     = 1'b0;
        repeat (8) begin
            @(posedge sysclk);
            oe_any = oe_any | bus_d_oe;
        end
        rdata   = bus_d_out;                    // Last strobe cycle
        oe_last = bus_d_oe;
        #DRV_DLY;
        {bus_iorq_n, bus_rd_n, bus_wr_n, bus_m1_n} = 4'hF;
        repeat (5) begin
            @(posedge sysclk);
            oe_any = oe_any | bus_d_oe;
        end
        check_bit("bus_d_oe after release", bus_d_oe, 1'b0);
    endtask

    task automatic write_io(input aq_bus_pkg::io_port_t port, input aq_bus_pkg::data_t wdata);
        aq_bus_pkg::data_t unused_rd;
        logic              unused_last, oe_any;
        io_access(port, wdata, 1'b0, 1'b1, unused_rd, unused_last, oe_any);
        check_bit("bus_d_oe during write", oe_any, 1'b0);
    endtask

    task automatic read_io(input aq_bus_pkg::io_port_t port, output aq_bus_pkg::data_t rdata,
                           output logic oe_last, output logic oe_any);
        io_access(port, 8'h00, 1'b1, 1'b1, rdata, oe_last, oe_any);
    endtask

    task automatic check_quadrants(input aq_bus_pkg::bank_t [3:0] exp);
        for (int q = 0; q < 4; q++) begin
            @(posedge sysclk);
            #DRV_DLY;
            bus_a = {2'(q), 14'h0155};
            @(posedge sysclk);
            check_bank($sformatf("bus_ba quadrant %0d", q), bus_ba, exp[q]);
        end
    endtask

    // Counts full load_n pulses, low then high again
    task automatic wait_load_pulses(input int n);
        int   count    = 0;
        logic seen_low = 1'b0;
        logic prev_ld  = hctrl_load_n;
        while (count < n) begin
            @(posedge sysclk);
            if (prev_ld && !hctrl_load_n) seen_low = 1'b1;
            if (!prev_ld && hctrl_load_n && seen_low) count++;
            prev_ld = hctrl_load_n;
        end
    endtask

    task automatic check_phi();
        int   interval = 0;
        int   toggles  = 0;
        logic prev_phi = phi;
        while (toggles < 41) begin
            @(posedge sysclk);
            interval++;
            if (phi !== prev_phi) begin
                if (toggles > 0 && interval != int'(PHI_DIV / 2))
                    stop_on_error($sformatf("FAILED time=%0t phi half period got=%0d expected=%0d",
                                            $time, interval, PHI_DIV / 2));
                toggles++;
                interval = 0;
                prev_phi = phi;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table, expected banks follow a shadow copy of the registers
    task automatic build_table();
        aq_bus_pkg::data_t shadow [4];
        logic [31:0]       seed = 32'd45;
        logic [1:0]        idx;
        for (int q = 0; q < 4; q++) shadow[q] = aq_bus_pkg::data_t'(q);
        for (int r = 0; r < N_ROWS; r++) begin
            seed = lcg_next(seed);
            table_q[r].kind    = ROW_KIND[r];
            table_q[r].port    = ROW_PORT[r];
            table_q[r].wval    = seed[23:16];
            table_q[r].pattern = seed[31:16];
            idx = 2'(ROW_PORT[r] - aq_bus_pkg::PORT_BANK0);
            if (ROW_KIND[r] == ROW_BANK) shadow[idx] = seed[23:16];
            table_q[r].exp_rd  = (ROW_KIND[r] == ROW_PAD) ? table_q[r].pattern[15:8] : seed[23:16];
            table_q[r].exp_rd2 = table_q[r].pattern[7:0];
            for (int q = 0; q < 4; q++) table_q[r].exp_ba[q] = shadow[q][4:0];
        end
    endtask

    task automatic apply_row(input row_t row);
        aq_bus_pkg::data_t rd;
        logic              oe_last, oe_any;
        case (row.kind)
            ROW_BANK: begin
                write_io(row.port, row.wval);
                read_io(row.port, rd, oe_last, oe_any);
                check_bit("bus_d_oe", oe_last, 1'b1);
                check_data("bus_d_out bank read", rd, row.exp_rd);
            end
            ROW_PAD: begin
                @(posedge sysclk);
                #DRV_DLY;
                ctrl_pattern = row.pattern;     // New buttons on the model
                wait_load_pulses(2);
                read_io(aq_bus_pkg::PORT_HCTRL1, rd, oe_last, oe_any);
                check_data("bus_d_out pad1", rd, row.exp_rd);
                read_io(aq_bus_pkg::PORT_HCTRL2, rd, oe_last, oe_any);
                check_data("bus_d_out pad2", rd, row.exp_rd2);
            end
            ROW_OTHER: begin
                write_io(row.port, row.wval);
                read_io(row.port, rd, oe_last, oe_any);
                check_bit("bus_d_oe unlisted port", oe_any, 1'b0);
            end
            default: begin                      // Interrupt acknowledge, m1 low
                io_access(row.port, row.wval, 1'b0, 1'b0, rd, oe_last, oe_any);
                io_access(row.port, row.wval, 1'b1, 1'b0, rd, oe_last, oe_any);
                check_bit("bus_d_oe interrupt ack", oe_any, 1'b0);
            end
        endcase
        check_quadrants(row.exp_ba);
    endtask

    initial begin
        aq_bus_pkg::data_t rd;
        logic              oe_last, oe_any;
        rst = 1'b1;
        bus_a = '0;
        bus_d_in = '0;
        {bus_iorq_n, bus_rd_n, bus_wr_n, bus_m1_n} = 4'hF;
        ctrl_pattern = '1;                      // No buttons pressed
        build_table();
        repeat (16) @(posedge sysclk);
        check_bit("phi", phi, 1'b0);
        check_bit("hctrl_clk", hctrl_clk, 1'b0);
        check_bit("hctrl_load_n", hctrl_load_n, 1'b1);
        check_bit("bus_d_oe", bus_d_oe, 1'b0);
        #DRV_DLY;
        rst = 1'b0;
        check_quadrants({5'd3, 5'd2, 5'd1, 5'd0});
        read_io(aq_bus_pkg::PORT_HCTRL1, rd, oe_last, oe_any);
        check_data("bus_d_out pad1 idle", rd, 8'hFF);
        read_io(aq_bus_pkg::PORT_HCTRL2, rd, oe_last, oe_any);
        check_data("bus_d_out pad2 idle", rd, 8'hFF);
        check_phi();
        for (int r = 0; r < N_ROWS; r++) apply_row(table_q[r]);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Simulation finished: FAIL");
            $fatal(1, "Errors were found");
        end
    end

endmodule

// ==== aq_core_top.f ====
aq_bus_pkg.sv
aq_hctrl_pkg.sv
phi_gen.sv
bus_decode.sv
io_port_block.sv
handctrl.sv
aq_core_top.sv
aq_core_chk.sv
tb_aq_core_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_aq_core_top
FILELIST   := aq_core_top.f
SOURCES    := $(shell cat $(FILELIST))
SIM_FLAGS  := --binary --timing --assert -j 0 --top-module $(TOP)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
SIM_BIN    := obj_dir/V$(TOP)

.PHONY: all run lint clean

all: run

run: $(SIM_BIN)
	./$(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf obj_dir
